// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = regblk_tb
FILE_LIST = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_TEXT = CHECKS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS = 40
)(
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

// File: bench/regblk_tb.sv
`timescale 1ns/1ps

module regblk_tb;

  localparam int WAIT_CYCLES   = 2;
  localparam int DEPTH         = 16;
  localparam int RESET_CYCLES  = 10;
  localparam int N_INTERNAL    = 40;
  localparam int N_UNMAPPED    = 20;
  localparam int N_WINDOW      = 24;
  localparam int N_MIXED       = 300;
  // reset reads, write/read pairs, error phase, window triples and the random mix.
  localparam int N_TRANSACTIONS = 3 + 2 * N_INTERNAL + (N_UNMAPPED + 4) + 3 * N_WINDOW + N_MIXED;
  localparam int TIMEOUT_CYCLES = N_TRANSACTIONS * (WAIT_CYCLES + 8) + 100;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic [31:0] control_out;

  integer      seed;
  int          cycle_count = 0;
  logic [31:0] control_model;
  logic [31:0] scratch_model;
  logic [31:0] mem_model [DEPTH];

  clock_gen #(.PERIOD_NS(40)) u_clock_gen (.o_clk(clk));

  regblk_top #(
    .WAIT_CYCLES (WAIT_CYCLES),
    .DEPTH       (DEPTH)
  ) i_regblk_top (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_wb_cyc  (wb_cyc),
    .i_wb_stb  (wb_stb),
    .i_wb_we   (wb_we),
    .i_wb_adr  (wb_adr),
    .i_wb_dat  (wb_dat_w),
    .i_wb_sel  (wb_sel),
    .o_wb_dat  (wb_dat_r),
    .o_wb_ack  (wb_ack),
    .o_wb_err  (wb_err),
    .o_control (control_out)
  );

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: the run took more than %0d clock cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                              input logic [31:0] new_value,
                                              input logic [3:0]  sel);
    logic [31:0] result;
    result = old_value;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        result[8*b +: 8] = new_value[8*b +: 8];
      end
    end
    return result;
  endfunction

  // reference model of the address map. updates the model state on a successful write.
  task automatic predict_access(input logic we, input logic [7:0] addr, input logic [31:0] data,
                                input logic [3:0] sel, output logic exp_err,
                                output logic [31:0] exp_data, output logic in_window);
    logic [7:0] word_addr;
    logic [7:0] offset;
    logic [3:0] index;
    word_addr = {addr[7:2], 2'b00};
    offset    = word_addr - regblk_pkg::WINDOW_START;
    index     = offset[5:2];
    exp_err   = 1'b0;
    exp_data  = '0;
    in_window = 1'b0;
    if (word_addr == regblk_pkg::REG_ID_ADDR) begin
      if (we) begin
        exp_err = 1'b1;
      end else begin
        exp_data = regblk_pkg::ID_VALUE;
      end
    end else if (word_addr == regblk_pkg::REG_CONTROL_ADDR) begin
      if (we) begin
        control_model = merge_bytes(control_model, data, sel);
      end
      exp_data = control_model;
    end else if (word_addr == regblk_pkg::REG_SCRATCH_ADDR) begin
      if (we) begin
        scratch_model = merge_bytes(scratch_model, data, sel);
      end
      exp_data = scratch_model;
    end else if (word_addr >= regblk_pkg::WINDOW_START && word_addr <= regblk_pkg::WINDOW_END) begin
      in_window = 1'b1;
      exp_data  = mem_model[index];
      if (we) begin
        mem_model[index] = merge_bytes(mem_model[index], data, sel);
      end
    end else begin
      exp_err = 1'b1;
    end
  endtask

  // one Wishbone classic cycle. called and returning on a falling edge.
  task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] sel, output logic got_ack, output logic got_err,
                             output logic [31:0] got_data, output int latency);
    latency  = 0;
    got_ack  = 1'b0;
    got_err  = 1'b0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_dat_w = data;
    wb_sel   = sel;
    while (!got_ack && !got_err) begin
      @(negedge clk);
      latency++;
      got_ack = wb_ack;
      got_err = wb_err;
    end
    got_data = wb_dat_r;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    @(negedge clk);
  endtask

  task automatic checked_access(input string test, input logic we, input logic [7:0] addr,
                                input logic [31:0] data, input logic [3:0] sel);
    string       name;
    logic        exp_err;
    logic [31:0] exp_data;
    logic        in_window;
    logic        got_ack;
    logic        got_err;
    logic [31:0] got_data;
    int          latency;
    name = $sformatf("%s %s @%h", test, we ? "write" : "read", addr);
    predict_access(we, addr, data, sel, exp_err, exp_data, in_window);
    host_access(we, addr, data, sel, got_ack, got_err, got_data, latency);
    check_value({name, " ack"}, 32'(!exp_err), 32'(got_ack));
    check_value({name, " err"}, 32'(exp_err), 32'(got_err));
    if (!we && !exp_err) begin
      check_value({name, " read data"}, exp_data, got_data);
    end
    if (!in_window) begin
      check_value({name, " latency"}, 32'd2, 32'(latency));
    end
    check_value({name, " single-cycle response"}, 32'd0, 32'({wb_ack, wb_err}));
    check_value({name, " control output"}, control_model, control_out);
  endtask

  function automatic logic [7:0] random_unmapped();
    logic [31:0] r;
    r = $random(seed);
    if (r[8]) begin
      return 8'h0C + (r[7:0] % 8'd116);
    end
    return {2'b11, r[5:0]};
  endfunction

  task automatic check_reset_state();
    check_value("reset control output", 32'd0, control_out);
    checked_access("reset", 1'b0, regblk_pkg::REG_ID_ADDR, '0, 4'hF);
    checked_access("reset", 1'b0, regblk_pkg::REG_CONTROL_ADDR, '0, 4'hF);
    checked_access("reset", 1'b0, regblk_pkg::REG_SCRATCH_ADDR, '0, 4'hF);
  endtask

  task automatic run_internal_writes();
    logic [31:0] r;
    logic [7:0]  addr;
    for (int i = 0; i < N_INTERNAL; i++) begin
      r    = $random(seed);
      addr = (r[0] ? regblk_pkg::REG_CONTROL_ADDR : regblk_pkg::REG_SCRATCH_ADDR) | {6'b0, r[2:1]};
      checked_access("internal", 1'b1, addr, $random(seed), r[6:3]);
      checked_access("internal", 1'b0, addr, '0, r[10:7]);
    end
  endtask

  task automatic run_error_accesses();
    logic [31:0] r;
    r = $random(seed);
    checked_access("error", 1'b1, {6'b0, r[1:0]}, $random(seed), 4'hF);
    for (int i = 0; i < N_UNMAPPED; i++) begin
      r = $random(seed);
      checked_access("error", r[0], random_unmapped(), $random(seed), r[4:1]);
    end
    // nothing above may have changed a register.
    checked_access("error", 1'b0, regblk_pkg::REG_ID_ADDR, '0, 4'hF);
    checked_access("error", 1'b0, regblk_pkg::REG_CONTROL_ADDR, '0, 4'hF);
    checked_access("error", 1'b0, regblk_pkg::REG_SCRATCH_ADDR, '0, 4'hF);
  endtask

  task automatic run_window_accesses();
    logic [31:0] r;
    logic [7:0]  addr;
    for (int i = 0; i < N_WINDOW; i++) begin
      r    = $random(seed);
      addr = regblk_pkg::WINDOW_START + {2'b00, r[5:0]};
      checked_access("window", 1'b1, addr, $random(seed), r[9:6]);
      // read the same word through a different byte offset.
      checked_access("window", 1'b0, {addr[7:2], r[11:10]}, '0, 4'hF);
      checked_access("window", 1'b0, regblk_pkg::WINDOW_START + {2'b00, r[17:12]}, '0, 4'hF);
    end
  endtask

  task automatic run_mixed_accesses();
    logic [31:0] r;
    logic [7:0]  addr;
    for (int i = 0; i < N_MIXED; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    addr = r[9:2] % 8'd12;
        2'd1:    addr = {2'b10, r[7:2]};
        2'd2:    addr = random_unmapped();
        default: addr = r[9:2];
      endcase
      checked_access("mixed", r[10], addr, $random(seed), r[14:11]);
    end
  endtask

  initial begin
    seed          = 60511;
    control_model = '0;
    scratch_model = '0;
    for (int i = 0; i < DEPTH; i++) begin
      mem_model[i] = '0;
    end
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_reset_state();
    run_internal_writes();
    run_error_accesses();
    run_window_accesses();
    run_mixed_accesses();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: design/address_decoder.sv
`timescale 1ns/1ps

module address_decoder #(
  parameter logic [regblk_pkg::ADDRESS_WIDTH-1:0] START_ADDRESS = '0,
  parameter logic [regblk_pkg::ADDRESS_WIDTH-1:0] END_ADDRESS   = '0,
  parameter bit                                   READABLE      = 1'b1,
  parameter bit                                   WRITABLE      = 1'b1
)(
  input  logic [regblk_pkg::ADDRESS_WIDTH-1:0] i_address,
  input  regblk_pkg::access_e                  i_access,
  output logic                                 o_match
);

  localparam int AW  = regblk_pkg::ADDRESS_WIDTH;
  localparam int LSB = $clog2(regblk_pkg::BUS_WIDTH) - 3;

  logic [AW-1:0] aligned;
  logic          in_range;
  logic          allowed;

  // byte lanes inside a word do not take part in the decode.
  assign aligned  = {i_address[AW-1:LSB], {LSB{1'b0}}};
  assign in_range = (aligned >= START_ADDRESS) && (aligned <= END_ADDRESS);

  always_comb begin
    if (i_access == regblk_pkg::ACCESS_WRITE) begin
      allowed = WRITABLE;
    end else begin
      allowed = READABLE;
    end
  end

  // a write to a read-only register is left undecoded, so the bridge ends it with an error.
  assign o_match = in_range && allowed;

endmodule

// File: design/ctrl_registers.sv
`timescale 1ns/1ps

module ctrl_registers (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_reg_valid,
  input  regblk_pkg::access_e                  i_reg_access,
  input  logic [regblk_pkg::ADDRESS_WIDTH-1:0] i_reg_address,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_reg_write_data,
  input  logic [regblk_pkg::STROBE_WIDTH-1:0]  i_reg_strobe,
  output logic                                 o_reg_active,
  output logic                                 o_reg_ready,
  output regblk_pkg::status_e                  o_reg_status,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_reg_read_data,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_control
);

  logic                             id_match;
  logic                             control_match;
  logic                             scratch_match;
  logic                             write;
  logic [regblk_pkg::BUS_WIDTH-1:0] control;
  logic [regblk_pkg::BUS_WIDTH-1:0] scratch;

  address_decoder #(
    .START_ADDRESS (regblk_pkg::REG_ID_ADDR),
    .END_ADDRESS   (regblk_pkg::REG_ID_ADDR),
    .READABLE      (1'b1),
    .WRITABLE      (1'b0)
  ) u_id_decoder (
    .i_address (i_reg_address),
    .i_access  (i_reg_access),
    .o_match   (id_match)
  );

  address_decoder #(
    .START_ADDRESS (regblk_pkg::REG_CONTROL_ADDR),
    .END_ADDRESS   (regblk_pkg::REG_CONTROL_ADDR),
    .READABLE      (1'b1),
    .WRITABLE      (1'b1)
  ) u_control_decoder (
    .i_address (i_reg_address),
    .i_access  (i_reg_access),
    .o_match   (control_match)
  );

  address_decoder #(
    .START_ADDRESS (regblk_pkg::REG_SCRATCH_ADDR),
    .END_ADDRESS   (regblk_pkg::REG_SCRATCH_ADDR),
    .READABLE      (1'b1),
    .WRITABLE      (1'b1)
  ) u_scratch_decoder (
    .i_address (i_reg_address),
    .i_access  (i_reg_access),
    .o_match   (scratch_match)
  );

  assign write = i_reg_valid && (i_reg_access == regblk_pkg::ACCESS_WRITE);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      control <= '0;
      scratch <= '0;
    end else if (write) begin
      for (int i = 0; i < regblk_pkg::STROBE_WIDTH; i++) begin
        if (i_reg_strobe[i] && control_match) begin
          control[8*i +: 8] <= i_reg_write_data[8*i +: 8];
        end
        if (i_reg_strobe[i] && scratch_match) begin
          scratch[8*i +: 8] <= i_reg_write_data[8*i +: 8];
        end
      end
    end
  end

  // internal registers always answer in the cycle of the request.
  assign o_reg_active = id_match || control_match || scratch_match;
  assign o_reg_ready  = i_reg_valid && o_reg_active;
  assign o_reg_status = regblk_pkg::STATUS_OKAY;

  always_comb begin
    if (id_match) begin
      o_reg_read_data = regblk_pkg::ID_VALUE;
    end else if (control_match) begin
      o_reg_read_data = control;
    end else if (scratch_match) begin
      o_reg_read_data = scratch;
    end else begin
      o_reg_read_data = '0;
    end
  end

  assign o_control = control;

endmodule

// File: design/ext_word_memory.sv
`timescale 1ns/1ps

module ext_word_memory #(
  parameter int WAIT_CYCLES = 2,
  parameter int DEPTH       = 16
)(
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_ext_cyc,
  input  logic                                 i_ext_stb,
  input  logic                                 i_ext_we,
  input  logic [regblk_pkg::ADDRESS_WIDTH-3:0] i_ext_adr,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_ext_dat_w,
  input  logic [regblk_pkg::STROBE_WIDTH-1:0]  i_ext_sel,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_ext_dat_r,
  output logic                                 o_ext_ack
);

  localparam int                   INDEX_WIDTH = $clog2(DEPTH);
  localparam int                   COUNT_WIDTH = $clog2(WAIT_CYCLES + 2);
  localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(WAIT_CYCLES);

  logic [regblk_pkg::BUS_WIDTH-1:0] mem [DEPTH];
  logic [COUNT_WIDTH-1:0]           count;
  logic [INDEX_WIDTH-1:0]           index;
  logic                             finish;

  assign index  = i_ext_adr[INDEX_WIDTH-1:0];
  assign finish = i_ext_cyc && i_ext_stb && !o_ext_ack && (count == LAST_COUNT);

  // ack comes WAIT_CYCLES+1 cycles after the strobe is first seen and lasts one cycle.
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      count     <= '0;
      o_ext_ack <= 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (o_ext_ack) begin
      o_ext_ack <= 1'b0;
    end else if (finish) begin
      count     <= '0;
      o_ext_ack <= 1'b1;
      for (int b = 0; b < regblk_pkg::STROBE_WIDTH; b++) begin
        if (i_ext_we && i_ext_sel[b]) begin
          mem[index][8*b +: 8] <= i_ext_dat_w[8*b +: 8];
        end
      end
    end else if (i_ext_cyc && i_ext_stb) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (finish) begin
      o_ext_dat_r <= mem[index];
    end
  end

endmodule

// File: design/external_window.sv
`timescale 1ns/1ps

module external_window #(
  parameter logic [regblk_pkg::ADDRESS_WIDTH-1:0] START_ADDRESS = '0,
  parameter logic [regblk_pkg::ADDRESS_WIDTH-1:0] END_ADDRESS   = '0
)(
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_reg_valid,
  input  regblk_pkg::access_e                  i_reg_access,
  input  logic [regblk_pkg::ADDRESS_WIDTH-1:0] i_reg_address,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_reg_write_data,
  input  logic [regblk_pkg::STROBE_WIDTH-1:0]  i_reg_strobe,
  output logic                                 o_reg_active,
  output logic                                 o_reg_ready,
  output regblk_pkg::status_e                  o_reg_status,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_reg_read_data,
  output logic                                 o_ext_cyc,
  output logic                                 o_ext_stb,
  output logic                                 o_ext_we,
  output logic [regblk_pkg::ADDRESS_WIDTH-3:0] o_ext_adr,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_ext_dat_w,
  output logic [regblk_pkg::STROBE_WIDTH-1:0]  o_ext_sel,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_ext_dat_r,
  input  logic                                 i_ext_ack
);

  logic                                 match;
  logic                                 start;
  logic [regblk_pkg::ADDRESS_WIDTH-1:0] offset;

  address_decoder #(
    .START_ADDRESS (START_ADDRESS),
    .END_ADDRESS   (END_ADDRESS),
    .READABLE      (1'b1),
    .WRITABLE      (1'b1)
  ) u_decoder (
    .i_address (i_reg_address),
    .i_access  (i_reg_access),
    .o_match   (match)
  );

  assign start  = i_reg_valid && match && !o_ext_stb;
  assign offset = i_reg_address - START_ADDRESS;

  // the cycle stays open until the memory acknowledges.
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ext_stb <= 1'b0;
      o_ext_we  <= 1'b0;
    end else if (o_ext_stb && i_ext_ack) begin
      o_ext_stb <= 1'b0;
    end else if (start) begin
      o_ext_stb <= 1'b1;
      o_ext_we  <= (i_reg_access == regblk_pkg::ACCESS_WRITE);
    end
  end

  always_ff @(posedge i_clk) begin
    if (start) begin
      o_ext_adr   <= offset[regblk_pkg::ADDRESS_WIDTH-1:2];
      o_ext_dat_w <= i_reg_write_data;
      o_ext_sel   <= i_reg_strobe;
    end
  end

  assign o_ext_cyc       = o_ext_stb;
  assign o_reg_active    = match;
  assign o_reg_ready     = o_ext_stb ? i_ext_ack : 1'b0;
  assign o_reg_status    = regblk_pkg::STATUS_OKAY;
  assign o_reg_read_data = i_ext_dat_r;

endmodule

// File: design/host_bus_bridge.sv
`timescale 1ns/1ps

module host_bus_bridge (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_wb_cyc,
  input  logic                                 i_wb_stb,
  input  logic                                 i_wb_we,
  input  logic [regblk_pkg::ADDRESS_WIDTH-1:0] i_wb_adr,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_wb_dat,
  input  logic [regblk_pkg::STROBE_WIDTH-1:0]  i_wb_sel,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_wb_dat,
  output logic                                 o_wb_ack,
  output logic                                 o_wb_err,
  output logic                                 o_reg_valid,
  output regblk_pkg::access_e                  o_reg_access,
  output logic [regblk_pkg::ADDRESS_WIDTH-1:0] o_reg_address,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_reg_write_data,
  output logic [regblk_pkg::STROBE_WIDTH-1:0]  o_reg_strobe,
  input  logic                                 i_regs_active,
  input  logic                                 i_regs_ready,
  input  regblk_pkg::status_e                  i_regs_status,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_regs_read_data,
  input  logic                                 i_win_active,
  input  logic                                 i_win_ready,
  input  regblk_pkg::status_e                  i_win_status,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_win_read_data
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } state_e;

  state_e                           state;
  logic                             start;
  logic                             done;
  logic                             done_error;
  logic [regblk_pkg::BUS_WIDTH-1:0] done_data;

  assign start = (state == IDLE) && i_wb_cyc && i_wb_stb;

  // the active slave answers. with none active the access ends at once as an error.
  always_comb begin
    done       = 1'b1;
    done_error = 1'b1;
    done_data  = '0;
    if (i_regs_active) begin
      done       = i_regs_ready;
      done_error = (i_regs_status == regblk_pkg::STATUS_ERROR);
      done_data  = i_regs_read_data;
    end else if (i_win_active) begin
      done       = i_win_ready;
      done_error = (i_win_status == regblk_pkg::STATUS_ERROR);
      done_data  = i_win_read_data;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state       <= IDLE;
      o_reg_valid <= 1'b0;
      o_wb_ack    <= 1'b0;
      o_wb_err    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state       <= ACCESS;
            o_reg_valid <= 1'b1;
          end
        end
        ACCESS: begin
          if (done) begin
            state       <= RESPOND;
            o_reg_valid <= 1'b0;
            o_wb_ack    <= !done_error;
            o_wb_err    <= done_error;
          end
        end
        RESPOND: begin
          // the host drops stb after this cycle, so no request is seen twice.
          state    <= IDLE;
          o_wb_ack <= 1'b0;
          o_wb_err <= 1'b0;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (start) begin
      o_reg_access     <= i_wb_we ? regblk_pkg::ACCESS_WRITE : regblk_pkg::ACCESS_READ;
      o_reg_address    <= i_wb_adr;
      o_reg_write_data <= i_wb_dat;
      o_reg_strobe     <= i_wb_sel;
    end
    if ((state == ACCESS) && done) begin
      o_wb_dat <= done_data;
    end
  end

endmodule

// File: design/regblk_pkg.sv
package regblk_pkg;

  // host addresses are byte addresses.
  localparam int ADDRESS_WIDTH = 8;
  localparam int BUS_WIDTH     = 32;
  localparam int STROBE_WIDTH  = BUS_WIDTH / 8;

  typedef enum logic {
    ACCESS_READ  = 1'b0,
    ACCESS_WRITE = 1'b1
  } access_e;

  typedef enum logic {
    STATUS_OKAY  = 1'b0,
    STATUS_ERROR = 1'b1
  } status_e;

  localparam logic [BUS_WIDTH-1:0] ID_VALUE = 32'h5247_0101;

  // internal registers.
  localparam logic [ADDRESS_WIDTH-1:0] REG_ID_ADDR      = 8'h00;
  localparam logic [ADDRESS_WIDTH-1:0] REG_CONTROL_ADDR = 8'h04;
  localparam logic [ADDRESS_WIDTH-1:0] REG_SCRATCH_ADDR = 8'h08;

  // external register window, sixteen words.
  localparam logic [ADDRESS_WIDTH-1:0] WINDOW_START = 8'h80;
  localparam logic [ADDRESS_WIDTH-1:0] WINDOW_END   = 8'hBF;

endpackage

// File: design/regblk_top.sv
`timescale 1ns/1ps

module regblk_top #(
  parameter int WAIT_CYCLES = 2,
  parameter int DEPTH       = 16
)(
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_wb_cyc,
  input  logic                                 i_wb_stb,
  input  logic                                 i_wb_we,
  input  logic [regblk_pkg::ADDRESS_WIDTH-1:0] i_wb_adr,
  input  logic [regblk_pkg::BUS_WIDTH-1:0]     i_wb_dat,
  input  logic [regblk_pkg::STROBE_WIDTH-1:0]  i_wb_sel,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_wb_dat,
  output logic                                 o_wb_ack,
  output logic                                 o_wb_err,
  output logic [regblk_pkg::BUS_WIDTH-1:0]     o_control
);

  logic                                 reg_valid;
  regblk_pkg::access_e                  reg_access;
  logic [regblk_pkg::ADDRESS_WIDTH-1:0] reg_address;
  logic [regblk_pkg::BUS_WIDTH-1:0]     reg_write_data;
  logic [regblk_pkg::STROBE_WIDTH-1:0]  reg_strobe;

  logic                                 regs_active;
  logic                                 regs_ready;
  regblk_pkg::status_e                  regs_status;
  logic [regblk_pkg::BUS_WIDTH-1:0]     regs_read_data;

  logic                                 win_active;
  logic                                 win_ready;
  regblk_pkg::status_e                  win_status;
  logic [regblk_pkg::BUS_WIDTH-1:0]     win_read_data;

  logic                                 ext_cyc;
  logic                                 ext_stb;
  logic                                 ext_we;
  logic [regblk_pkg::ADDRESS_WIDTH-3:0] ext_adr;
  logic [regblk_pkg::BUS_WIDTH-1:0]     ext_dat_w;
  logic [regblk_pkg::STROBE_WIDTH-1:0]  ext_sel;
  logic [regblk_pkg::BUS_WIDTH-1:0]     ext_dat_r;
  logic                                 ext_ack;

  host_bus_bridge u_bridge (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_wb_cyc         (i_wb_cyc),
    .i_wb_stb         (i_wb_stb),
    .i_wb_we          (i_wb_we),
    .i_wb_adr         (i_wb_adr),
    .i_wb_dat         (i_wb_dat),
    .i_wb_sel         (i_wb_sel),
    .o_wb_dat         (o_wb_dat),
    .o_wb_ack         (o_wb_ack),
    .o_wb_err         (o_wb_err),
    .o_reg_valid      (reg_valid),
    .o_reg_access     (reg_access),
    .o_reg_address    (reg_address),
    .o_reg_write_data (reg_write_data),
    .o_reg_strobe     (reg_strobe),
    .i_regs_active    (regs_active),
    .i_regs_ready     (regs_ready),
    .i_regs_status    (regs_status),
    .i_regs_read_data (regs_read_data),
    .i_win_active     (win_active),
    .i_win_ready      (win_ready),
    .i_win_status     (win_status),
    .i_win_read_data  (win_read_data)
  );

  ctrl_registers u_registers (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_reg_valid      (reg_valid),
    .i_reg_access     (reg_access),
    .i_reg_address    (reg_address),
    .i_reg_write_data (reg_write_data),
    .i_reg_strobe     (reg_strobe),
    .o_reg_active     (regs_active),
    .o_reg_ready      (regs_ready),
    .o_reg_status     (regs_status),
    .o_reg_read_data  (regs_read_data),
    .o_control        (o_control)
  );

  external_window #(
    .START_ADDRESS (regblk_pkg::WINDOW_START),
    .END_ADDRESS   (regblk_pkg::WINDOW_END)
  ) u_window (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_reg_valid      (reg_valid),
    .i_reg_access     (reg_access),
    .i_reg_address    (reg_address),
    .i_reg_write_data (reg_write_data),
    .i_reg_strobe     (reg_strobe),
    .o_reg_active     (win_active),
    .o_reg_ready      (win_ready),
    .o_reg_status     (win_status),
    .o_reg_read_data  (win_read_data),
    .o_ext_cyc        (ext_cyc),
    .o_ext_stb        (ext_stb),
    .o_ext_we         (ext_we),
    .o_ext_adr        (ext_adr),
    .o_ext_dat_w      (ext_dat_w),
    .o_ext_sel        (ext_sel),
    .i_ext_dat_r      (ext_dat_r),
    .i_ext_ack        (ext_ack)
  );

  ext_word_memory #(
    .WAIT_CYCLES (WAIT_CYCLES),
    .DEPTH       (DEPTH)
  ) u_memory (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_ext_cyc   (ext_cyc),
    .i_ext_stb   (ext_stb),
    .i_ext_we    (ext_we),
    .i_ext_adr   (ext_adr),
    .i_ext_dat_w (ext_dat_w),
    .i_ext_sel   (ext_sel),
    .o_ext_dat_r (ext_dat_r),
    .o_ext_ack   (ext_ack)
  );

endmodule

// File: files.f
design/regblk_pkg.sv
design/address_decoder.sv
design/host_bus_bridge.sv
design/ctrl_registers.sv
design/external_window.sv
design/ext_word_memory.sv
design/regblk_top.sv
bench/clock_gen.sv
bench/regblk_tb.sv
